/* rtl/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data word width of the core and the SRAM
`define LSU_XLEN 32

// SRAM word-address width
`define LSU_AW 8

// Number of SRAM words
`define LSU_DEPTH (1 << `LSU_AW)

`endif

/* rtl/lsu_pkg.sv */
package lsu_pkg;

  // I-type view of the word, used by loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } load_t;

  // S-type view of the word, used by stores
  // Immediate is split around rs2/rs1/funct3
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } store_t;

  // One instruction word, decoded through either view
  typedef union packed {
    load_t  load;
    store_t store;
  } instr_u;

  // Access size, matches funct3[1:0] of the RV32 loads and stores
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } size_e;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

endpackage

/* rtl/lsu_decode.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  output logic                 instr_ready,
  input  lsu_pkg::instr_u      instr,
  input  logic [`LSU_XLEN-1:0] rs1_val,
  input  logic [`LSU_XLEN-1:0] rs2_val,
  input  logic                 issue,
  output logic                 dec_valid,
  output logic                 dec_is_store,
  output lsu_pkg::size_e       dec_size,
  output logic                 dec_unsigned,
  output logic [4:0]           dec_rd,
  output logic [`LSU_XLEN-1:0] dec_addr,
  output logic [`LSU_XLEN-1:0] dec_store_data,
  output logic                 illegal
);

  logic                 is_load;
  logic                 is_store;
  logic                 legal;
  logic                 accept;
  logic [2:0]           funct3;
  logic [`LSU_XLEN-1:0] imm;
  lsu_pkg::size_e       size;

  // Opcode sits in the same bits of both views
  assign is_load  = (instr.load.opcode == lsu_pkg::OPC_LOAD);
  assign is_store = (instr.store.opcode == lsu_pkg::OPC_STORE);
  assign funct3   = instr.load.funct3;

  // LB LH LW LBU LHU for loads, SB SH SW for stores
  always_comb begin
    legal = 1'b0;
    if (is_load) begin
      legal = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
    end else if (is_store) begin
      legal = !funct3[2] && (funct3[1:0] != 2'b11);
    end
  end

  // Immediate from whichever view the opcode selects, sign-extended
  always_comb begin
    if (is_store) begin
      imm = {{(`LSU_XLEN-12){instr.store.imm_hi[6]}}, instr.store.imm_hi,
             instr.store.imm_lo};
    end else begin
      imm = {{(`LSU_XLEN-12){instr.load.imm[11]}}, instr.load.imm};
    end
  end

  always_comb begin
    case (funct3[1:0])
      2'b00:   size = lsu_pkg::SIZE_B;
      2'b01:   size = lsu_pkg::SIZE_H;
      default: size = lsu_pkg::SIZE_W;
    endcase
  end

  // Register frees up in the cycle its operation issues
  assign instr_ready = !dec_valid || issue;
  assign accept      = instr_valid && instr_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      // Dropped word pulses illegal for one cycle
      illegal <= accept && !legal;
      if (accept && legal) begin
        dec_valid      <= 1'b1;
        dec_is_store   <= is_store;
        dec_size       <= size;
        dec_unsigned   <= funct3[2];
        dec_rd         <= instr.load.rd;
        dec_addr       <= rs1_val + imm;
        dec_store_data <= rs2_val;
      end else if (issue) begin
        dec_valid <= 1'b0;
      end
    end
  end

endmodule

/* rtl/lsu_execute.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_execute (
  input  logic                   dec_valid,
  input  logic                   dec_is_store,
  input  lsu_pkg::size_e         dec_size,
  input  logic                   dec_unsigned,
  input  logic [4:0]             dec_rd,
  input  logic [`LSU_XLEN-1:0]   dec_addr,
  input  logic [`LSU_XLEN-1:0]   dec_store_data,
  output logic                   issue,
  output logic [`LSU_XLEN-1:0]   araddr,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [`LSU_XLEN-1:0]   awaddr,
  output logic                   awvalid,
  output logic [`LSU_XLEN-1:0]   wdata,
  output logic [`LSU_XLEN/8-1:0] wstrb,
  output logic                   wvalid,
  output lsu_pkg::size_e         ld_size,
  output logic                   ld_unsigned,
  output logic [4:0]             ld_rd,
  output logic [1:0]             ld_offset
);

  logic [`LSU_XLEN-1:0] addr;
  logic [1:0]           offset;

  // Round down to natural alignment, no misaligned traps
  always_comb begin
    case (dec_size)
      lsu_pkg::SIZE_B: addr = dec_addr;
      lsu_pkg::SIZE_H: addr = {dec_addr[`LSU_XLEN-1:1], 1'b0};
      default:         addr = {dec_addr[`LSU_XLEN-1:2], 2'b00};
    endcase
  end

  assign offset = addr[1:0];

  // Byte lanes touched by the access
  always_comb begin
    case (dec_size)
      lsu_pkg::SIZE_B: wstrb = 4'b0001 << offset;
      lsu_pkg::SIZE_H: wstrb = 4'b0011 << offset;
      default:         wstrb = 4'b1111;
    endcase
  end

  // Replicate store data so every candidate lane carries it
  // Strobe then picks the lane that is written
  always_comb begin
    case (dec_size)
      lsu_pkg::SIZE_B: wdata = {4{dec_store_data[7:0]}};
      lsu_pkg::SIZE_H: wdata = {2{dec_store_data[15:0]}};
      default:         wdata = dec_store_data;
    endcase
  end

  assign araddr  = addr;
  assign awaddr  = addr;
  assign arvalid = dec_valid && !dec_is_store;
  assign awvalid = dec_valid && dec_is_store;
  assign wvalid  = dec_valid && dec_is_store;

  // Write side always accepts, so only loads can stall
  assign issue = dec_valid && (dec_is_store || arready);

  // Load attributes travel alongside the read request
  assign ld_size     = dec_size;
  assign ld_unsigned = dec_unsigned;
  assign ld_rd       = dec_rd;
  assign ld_offset   = offset;

endmodule

/* rtl/mem_sram.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_sram (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`LSU_XLEN-1:0]   araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [`LSU_XLEN-1:0]   rdata,
  output logic                   rvalid,
  input  logic                   rready,
  input  logic [`LSU_XLEN-1:0]   awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`LSU_XLEN-1:0]   wdata,
  input  logic [`LSU_XLEN/8-1:0] wstrb,
  input  logic                   wvalid,
  output logic                   wready
);

  logic [`LSU_XLEN-1:0] mem [`LSU_DEPTH];

  // Word addresses, byte offset shifted off
  logic [`LSU_AW-1:0] rd_word;
  logic [`LSU_AW-1:0] wr_word;

  // Response held while the consumer stalls
  logic                 hold_valid;
  logic [`LSU_XLEN-1:0] hold_data;

  assign rd_word = araddr[`LSU_AW+1:2];
  assign wr_word = awaddr[`LSU_AW+1:2];

  // No new read while a response is held
  // Release cycle hands out the held data, so the next read waits one more cycle
  assign arready = !hold_valid;

  // Fresh data in the cycle of the request, held data afterwards
  assign rdata  = hold_valid ? hold_data : mem[rd_word];
  assign rvalid = hold_valid || arvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (rvalid && !rready) begin
      hold_valid <= 1'b1;
    end else if (rready) begin
      hold_valid <= 1'b0;
    end
  end

  // Capturing rdata while holding just keeps the same word
  always_ff @(posedge clk) begin
    if (rvalid && !rready) begin
      hold_data <= rdata;
    end
  end

  // Write channels never stall
  assign awready = 1'b1;
  assign wready  = 1'b1;

  // Byte-strobed write, old data seen by a read in the same cycle
  // Whole array cleared at reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `LSU_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (awvalid && wvalid) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (wstrb[b]) begin
          mem[wr_word][b*8+:8] <= wdata[b*8+:8];
        end
      end
    end
  end

endmodule

/* rtl/lsu_result.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_result (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`LSU_XLEN-1:0] rdata,
  input  logic                 rvalid,
  output logic                 rready,
  input  lsu_pkg::size_e       ld_size,
  input  logic                 ld_unsigned,
  input  logic [4:0]           ld_rd,
  input  logic [1:0]           ld_offset,
  output logic                 result_valid,
  output logic [`LSU_XLEN-1:0] result_data,
  output logic [4:0]           result_rd,
  input  logic                 result_ready
);

  // Attribute copy taken when the SRAM starts holding a read
  // Execute moves on to the next operation meanwhile
  logic                 attr_held;
  lsu_pkg::size_e       held_size;
  logic                 held_unsigned;
  logic [4:0]           held_rd;
  logic [1:0]           held_offset;

  lsu_pkg::size_e       cur_size;
  logic                 cur_unsigned;
  logic [4:0]           cur_rd;
  logic [1:0]           cur_offset;
  logic [`LSU_XLEN-1:0] lane;
  logic [`LSU_XLEN-1:0] ext_data;

  assign cur_size     = attr_held ? held_size : ld_size;
  assign cur_unsigned = attr_held ? held_unsigned : ld_unsigned;
  assign cur_rd       = attr_held ? held_rd : ld_rd;
  assign cur_offset   = attr_held ? held_offset : ld_offset;

  // Same hold rule as the SRAM response register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      attr_held <= 1'b0;
    end else if (rvalid && !rready) begin
      attr_held <= 1'b1;
    end else if (rready) begin
      attr_held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid && !rready) begin
      held_size     <= cur_size;
      held_unsigned <= cur_unsigned;
      held_rd       <= cur_rd;
      held_offset   <= cur_offset;
    end
  end

  // Move the addressed lane down to bit 0
  assign lane = rdata >> {cur_offset, 3'b000};

  always_comb begin
    case (cur_size)
      lsu_pkg::SIZE_B: begin
        ext_data = {{(`LSU_XLEN-8){!cur_unsigned && lane[7]}}, lane[7:0]};
      end
      lsu_pkg::SIZE_H: begin
        ext_data = {{(`LSU_XLEN-16){!cur_unsigned && lane[15]}}, lane[15:0]};
      end
      default: ext_data = rdata;
    endcase
  end

  // Accept a new word whenever the output slot is empty or draining
  assign rready = !result_valid || result_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (rvalid && rready) begin
      result_valid <= 1'b1;
      result_data  <= ext_data;
      result_rd    <= cur_rd;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  output logic                 instr_ready,
  input  lsu_pkg::instr_u      instr,
  input  logic [`LSU_XLEN-1:0] rs1_val,
  input  logic [`LSU_XLEN-1:0] rs2_val,
  output logic                 result_valid,
  input  logic                 result_ready,
  output logic [`LSU_XLEN-1:0] result_data,
  output logic [4:0]           result_rd,
  output logic                 illegal
);

  // Decode to execute
  logic                 dec_valid;
  logic                 dec_is_store;
  lsu_pkg::size_e       dec_size;
  logic                 dec_unsigned;
  logic [4:0]           dec_rd;
  logic [`LSU_XLEN-1:0] dec_addr;
  logic [`LSU_XLEN-1:0] dec_store_data;
  logic                 issue;

  // Execute to SRAM
  logic [`LSU_XLEN-1:0]   araddr;
  logic                   arvalid;
  logic                   arready;
  logic [`LSU_XLEN-1:0]   awaddr;
  logic                   awvalid;
  logic [`LSU_XLEN-1:0]   wdata;
  logic [`LSU_XLEN/8-1:0] wstrb;
  logic                   wvalid;

  // SRAM and execute to result
  logic [`LSU_XLEN-1:0] rdata;
  logic                 rvalid;
  logic                 rready;
  lsu_pkg::size_e       ld_size;
  logic                 ld_unsigned;
  logic [4:0]           ld_rd;
  logic [1:0]           ld_offset;

  lsu_decode i_decode (
    .clk, .rst_n, .instr_valid, .instr_ready, .instr, .rs1_val, .rs2_val,
    .issue, .dec_valid, .dec_is_store, .dec_size, .dec_unsigned, .dec_rd,
    .dec_addr, .dec_store_data, .illegal
  );

  lsu_execute i_execute (
    .dec_valid, .dec_is_store, .dec_size, .dec_unsigned, .dec_rd, .dec_addr,
    .dec_store_data, .issue, .araddr, .arvalid, .arready, .awaddr, .awvalid,
    .wdata, .wstrb, .wvalid, .ld_size, .ld_unsigned, .ld_rd, .ld_offset
  );

  // Write readies are constant high inside the SRAM
  mem_sram i_sram (
    .clk, .rst_n, .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
    .awaddr, .awvalid, .awready(), .wdata, .wstrb, .wvalid, .wready()
  );

  lsu_result i_result (
    .clk, .rst_n, .rdata, .rvalid, .rready, .ld_size, .ld_unsigned, .ld_rd,
    .ld_offset, .result_valid, .result_data, .result_rd, .result_ready
  );

endmodule

/* tb/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb;

  // Run length and the cycle limit derived from it
  localparam int NUM_OPS        = 400;
  localparam int CYCLES_PER_OP  = 4;
  localparam int MARGIN         = 100;
  localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP + MARGIN;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic                 instr_ready;
  lsu_pkg::instr_u      instr;
  logic [`LSU_XLEN-1:0] rs1_val;
  logic [`LSU_XLEN-1:0] rs2_val;
  logic                 result_valid;
  logic                 result_ready;
  logic [`LSU_XLEN-1:0] result_data;
  logic [4:0]           result_rd;
  logic                 illegal;

  // Byte-wide reference memory covering the 1 KB SRAM
  logic [7:0]  mem_model [1024];
  logic [31:0] exp_data [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] lfsr_state;

  // Operation currently offered on the instruction port
  logic        cur_is_load;
  logic        cur_is_store;
  logic        cur_illegal;
  logic [1:0]  cur_size;
  logic        cur_uns;
  logic [31:0] cur_addr;
  logic [31:0] cur_data;
  logic [4:0]  cur_rd;
  logic [31:0] last_addr;

  logic        fire_in;
  logic        fire_res;
  logic        pend_illegal;
  logic        was_stalled;
  logic [31:0] held_data;
  logic [4:0]  held_rd;
  logic [31:0] coin;
  int          ops_sent;
  int          ops_done;
  int          cycles;

  lsu_top i_dut (
    .clk, .rst_n, .instr_valid, .instr_ready, .instr, .rs1_val, .rs2_val,
    .result_valid, .result_ready, .result_data, .result_rd, .illegal
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t %s", $time, why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // Pick a random load, store or illegal word and drive it
  task automatic make_instr();
    logic [31:0] kind;
    logic [31:0] sel;
    logic [31:0] t;
    logic [31:0] f;
    logic [31:0] u;
    logic [31:0] imm;
    logic [31:0] rdf;
    logic [31:0] r1f;
    logic [31:0] r2f;
    logic [31:0] sext;
    logic [2:0]  funct3;
    logic [6:0]  opc;
    // Half loads, a quarter stores, a quarter illegal
    draw(2, kind);
    // Reusing the last address gives load-after-store hits
    draw(2, sel);
    if (sel[1:0] == 2'd0) begin
      cur_addr = last_addr;
    end else begin
      draw(10, t);
      cur_addr = t;
    end
    draw(12, imm);
    draw(5, rdf);
    draw(5, r1f);
    draw(5, r2f);
    draw(32, cur_data);
    draw(2, f);
    draw(1, u);
    cur_size     = (f[1:0] == 2'd3) ? 2'd2 : f[1:0];
    cur_uns      = u[0] && (cur_size != 2'd2);
    cur_is_load  = (kind[1:0] < 2'd2);
    cur_is_store = (kind[1:0] == 2'd2);
    cur_illegal  = (kind[1:0] == 2'd3);
    cur_rd       = rdf[4:0];
    if (cur_illegal) begin
      draw(2, sel);
      case (sel[1:0])
        2'd0: begin
          // Unknown major opcode
          draw(7, t);
          opc = t[6:0];
          if (opc == lsu_pkg::OPC_LOAD || opc == lsu_pkg::OPC_STORE) begin
            opc = opc ^ 7'h10;
          end
          funct3 = 3'b000;
        end
        2'd1: begin
          // Load funct3 values 3, 6 and 7
          opc    = lsu_pkg::OPC_LOAD;
          funct3 = (f[1:0] == 2'd0) ? 3'b011 : {2'b11, f[0]};
        end
        default: begin
          opc    = lsu_pkg::OPC_STORE;
          funct3 = u[0] ? {1'b1, f[1:0]} : 3'b011;
        end
      endcase
    end else if (cur_is_load) begin
      opc    = lsu_pkg::OPC_LOAD;
      funct3 = {cur_uns, cur_size};
    end else begin
      opc    = lsu_pkg::OPC_STORE;
      funct3 = {1'b0, cur_size};
    end
    sext = {{20{imm[11]}}, imm[11:0]};
    // rs1 chosen so that rs1 + imm lands on the target byte
    rs1_val <= cur_addr - sext;
    rs2_val <= cur_data;
    if (cur_is_store) begin
      instr <= {imm[11:5], r2f[4:0], r1f[4:0], funct3, imm[4:0], opc};
    end else begin
      instr <= {imm[11:0], r1f[4:0], funct3, rdf[4:0], opc};
    end
    if (!cur_illegal) begin
      last_addr = cur_addr;
    end
  endtask

  // Reference behavior of an accepted operation
  task automatic apply_model();
    logic [9:0]  a;
    logic [15:0] h;
    logic [31:0] w;
    a = cur_addr[9:0];
    // Natural alignment by dropping the low bits
    if (cur_size == 2'd1) begin
      a[0] = 1'b0;
    end else if (cur_size == 2'd2) begin
      a[1:0] = 2'b00;
    end
    if (cur_is_store) begin
      mem_model[a] = cur_data[7:0];
      if (cur_size != 2'd0) begin
        mem_model[a+1] = cur_data[15:8];
      end
      if (cur_size == 2'd2) begin
        mem_model[a+2] = cur_data[23:16];
        mem_model[a+3] = cur_data[31:24];
      end
    end else if (cur_is_load) begin
      case (cur_size)
        2'd0: w = cur_uns ? {24'd0, mem_model[a]} : {{24{mem_model[a][7]}}, mem_model[a]};
        2'd1: begin
          h = {mem_model[a+1], mem_model[a]};
          w = cur_uns ? {16'd0, h} : {{16{h[15]}}, h};
        end
        default: w = {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
      endcase
      exp_data.push_back(w);
      exp_rd.push_back(cur_rd);
    end
  endtask

  initial begin
    lfsr_state   = 32'd59;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    rs1_val      = '0;
    rs2_val      = '0;
    result_ready = 1'b0;
    last_addr    = '0;
    pend_illegal = 1'b0;
    was_stalled  = 1'b0;
    ops_sent     = 0;
    ops_done     = 0;
    for (int i = 0; i < 1024; i++) begin
      mem_model[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    while (ops_done < NUM_OPS || exp_data.size() != 0) begin
      // Sample between edges, where all DUT outputs are settled
      @(negedge clk);
      check_value("illegal", pend_illegal, illegal);
      if (was_stalled) begin
        check_value("result_valid", 1, result_valid);
        check_value("result_data", held_data, result_data);
        check_value("result_rd", held_rd, result_rd);
      end
      fire_res = result_valid && result_ready;
      if (fire_res) begin
        if (exp_data.size() == 0) begin
          abort_run("A load result arrived that no load asked for");
        end
        check_value("result_data", exp_data.pop_front(), result_data);
        check_value("result_rd", exp_rd.pop_front(), result_rd);
      end
      was_stalled = result_valid && !result_ready;
      held_data   = result_data;
      held_rd     = result_rd;
      fire_in     = instr_valid && instr_ready;
      pend_illegal = fire_in && cur_illegal;
      if (fire_in) begin
        apply_model();
        ops_done++;
      end
      @(posedge clk);
      // Valid stays up with stable data until the transfer
      if (fire_in || !instr_valid) begin
        draw(2, coin);
        if (ops_sent < NUM_OPS && coin[1:0] != 2'd0) begin
          make_instr();
          instr_valid <= 1'b1;
          ops_sent++;
        end else begin
          instr_valid <= 1'b0;
        end
      end
      draw(2, coin);
      result_ready <= (coin[1:0] != 2'd0);
    end
    // Nothing may follow the last expected result
    result_ready <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("illegal", pend_illegal, illegal);
      check_value("result_valid", 0, result_valid);
      pend_illegal = 1'b0;
    end
    $display("Simulation passed");
    $finish;
  end

  // Watchdog on total run length
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the load results stopped arriving", cycles);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

/* lsu_subsys.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/mem_sram.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
tb/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_decode.sv
      - rtl/lsu_execute.sv
      - rtl/mem_sram.sv
      - rtl/lsu_result.sv
      - rtl/lsu_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/lsu_tb.sv
